//--- hw/rayGen_params.svh
`ifndef RAYGEN_PARAMS_SVH
`define RAYGEN_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Frame geometry
////////////////////////////////////////////////////////////////////////////

// Pixels per line
`define FRAME_WIDTH 8

// Lines per frame
`define FRAME_HEIGHT 4

////////////////////////////////////////////////////////////////////////////
// Lanes and number formats
////////////////////////////////////////////////////////////////////////////

// Ray setup lanes fed round robin
`define CORE_COUNT 3
// Enough bits to index every lane
`define CORE_INDEX_WIDTH 2

// Screen coordinate width
`define COORD_WIDTH 10
// Fraction bits of the 16.16 format
`define FRAC_BITS 16

`endif

//--- hw/fixedPkg.sv
package fixedPkg;

    ////////////////////////////////////////////////////////////////////////
    // Fixed point scalar
    ////////////////////////////////////////////////////////////////////////

    // Signed 16.16 number
    // Integer part in the upper half, fraction in the lower half
    typedef logic signed [31:0] Fixed;

    ////////////////////////////////////////////////////////////////////////
    // Fixed point vector
    ////////////////////////////////////////////////////////////////////////

    // Three components packed x first
    // Used for camera vectors and ray directions
    typedef struct packed {
        // Horizontal component
        Fixed x;
        // Vertical component
        Fixed y;
        // Depth component
        Fixed z;
    } Vec3;

endpackage

//--- hw/rayPkg.sv
`include "rayGen_params.svh"

package rayPkg;

    ////////////////////////////////////////////////////////////////////////
    // Screen space and camera
    ////////////////////////////////////////////////////////////////////////

    // Unsigned pixel coordinate
    typedef logic [`COORD_WIDTH-1:0] ScreenCoord;

    // Camera description, held stable for a whole frame
    typedef struct packed {
        // Camera position
        fixedPkg::Vec3 pos;
        // Bottom left corner of the viewport
        fixedPkg::Vec3 blc;
        // Horizontal and vertical extents
        fixedPkg::Vec3 rh;
        fixedPkg::Vec3 rv;
        // Per pixel scale factors
        fixedPkg::Fixed cub;
        fixedPkg::Fixed cvb;
        // Viewport height in lines
        ScreenCoord vpHeight;
    } CameraParams;

    ////////////////////////////////////////////////////////////////////////
    // Lane output and scanner state
    ////////////////////////////////////////////////////////////////////////

    // One primary ray thread
    typedef struct packed {
        logic valid;
        ScreenCoord x;
        ScreenCoord y;
        fixedPkg::Vec3 dir;
    } ThreadData;

    // Pixel walk states
    typedef enum logic [1:0] {
        scanInit,
        scanWait,
        scanGenerate,
        scanNext
    } ScanState;

endpackage

//--- hw/pixelScanner.sv
`timescale 1ns/1ps

`include "rayGen_params.svh"

module pixelScanner (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        restart,
    input  logic                        start,
    input  rayPkg::ScreenCoord          x0,
    input  rayPkg::ScreenCoord          y0,
    input  logic [`CORE_COUNT-1:0]      fifoFull,
    output logic [`CORE_COUNT-1:0]      issue,
    output rayPkg::ScreenCoord          pixelX,
    output rayPkg::ScreenCoord          pixelY,
    output logic                        frameDone
);

    ////////////////////////////////////////////////////////////////////////
    // Scan state
    ////////////////////////////////////////////////////////////////////////

    rayPkg::ScanState              state;
    // Pixel about to be issued
    rayPkg::ScreenCoord            curX;
    rayPkg::ScreenCoord            curY;
    // Round robin pointer
    logic [`CORE_INDEX_WIDTH-1:0]  laneIdx;

    // Derived from the current pixel and lane
    rayPkg::ScreenCoord            nextX;
    rayPkg::ScreenCoord            nextY;
    logic                          lineEnd;
    logic                          frameEnd;
    logic                          lastLane;
    logic                          laneReady;

    ////////////////////////////////////////////////////////////////////////
    // Next pixel and lane decode
    ////////////////////////////////////////////////////////////////////////

    assign nextX = curX + 1'b1;
    assign nextY = curY + 1'b1;

    // Line wraps once x runs past the last column
    assign lineEnd = (nextX >= `FRAME_WIDTH);
    // Frame ends on the wrap out of the last line
    assign frameEnd = lineEnd && (nextY >= `FRAME_HEIGHT);

    assign lastLane = (laneIdx == `CORE_INDEX_WIDTH'(`CORE_COUNT - 1));

    // Current lane can take a pixel
    assign laneReady = !fifoFull[laneIdx];

    ////////////////////////////////////////////////////////////////////////
    // Issue strobes
    ////////////////////////////////////////////////////////////////////////

    // One hot pulse to the lane being served
    // Held off while that lane reports full
    always_comb begin
        issue = '0;
        if (state == rayPkg::scanGenerate && laneReady) begin
            issue[laneIdx] = 1'b1;
        end
    end

    // Pixel is shared by all lanes and qualified by issue
    assign pixelX = curX;
    assign pixelY = curY;

    ////////////////////////////////////////////////////////////////////////
    // Scan FSM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= rayPkg::scanInit;
            curX      <= '0;
            curY      <= '0;
            laneIdx   <= '0;
            frameDone <= 1'b0;
        end else begin
            // Pulse lasts one cycle only
            frameDone <= 1'b0;

            case (state)
                rayPkg::scanInit: begin
                    // Load start pixel and rewind the lane pointer
                    if (restart) begin
                        curX    <= x0;
                        curY    <= y0;
                        laneIdx <= '0;
                        state   <= rayPkg::scanWait;
                    end
                end

                rayPkg::scanWait: begin
                    if (start) begin
                        state <= rayPkg::scanGenerate;
                    end
                end

                rayPkg::scanGenerate: begin
                    // Stay on this lane until it has room
                    if (laneReady) begin
                        state <= rayPkg::scanNext;
                    end
                end

                rayPkg::scanNext: begin
                    // Advance lane modulo lane count
                    if (lastLane) begin
                        laneIdx <= '0;
                    end else begin
                        laneIdx <= laneIdx + 1'b1;
                    end

                    // Raster step, each new line restarts at x0
                    if (lineEnd) begin
                        curX <= x0;
                        curY <= nextY;
                    end else begin
                        curX <= nextX;
                    end

                    if (frameEnd) begin
                        frameDone <= 1'b1;
                        state     <= rayPkg::scanInit;
                    end else begin
                        state <= rayPkg::scanGenerate;
                    end
                end

                default: begin
                    state <= rayPkg::scanInit;
                end
            endcase
        end
    end

endmodule

//--- hw/rayLane.sv
`timescale 1ns/1ps

`include "rayGen_params.svh"

module rayLane (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 issue,
    input  rayPkg::ScreenCoord   pixelX,
    input  rayPkg::ScreenCoord   pixelY,
    input  rayPkg::CameraParams  camera,
    output rayPkg::ThreadData    thread
);

    ////////////////////////////////////////////////////////////////////////
    // Fixed point helpers
    ////////////////////////////////////////////////////////////////////////

    // Full signed product rescaled back to 16.16
    function automatic fixedPkg::Fixed fixedMul(input fixedPkg::Fixed a,
                                                input fixedPkg::Fixed b);
        logic signed [63:0] prod;
        prod = a * b;
        return fixedPkg::Fixed'(prod >>> `FRAC_BITS);
    endfunction

    // One direction component
    // cu * h + cv * v + corner - position
    function automatic fixedPkg::Fixed dirComp(input fixedPkg::Fixed cu,
                                               input fixedPkg::Fixed cv,
                                               input fixedPkg::Fixed h,
                                               input fixedPkg::Fixed v,
                                               input fixedPkg::Fixed corner,
                                               input fixedPkg::Fixed position);
        return fixedMul(cu, h) + fixedMul(cv, v) + corner - position;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Stage one
    ////////////////////////////////////////////////////////////////////////

    fixedPkg::Fixed      fixX;
    fixedPkg::Fixed      fixY;

    logic                s1Valid;
    rayPkg::ScreenCoord  s1X;
    rayPkg::ScreenCoord  s1Y;
    fixedPkg::Fixed      s1Cu;
    fixedPkg::Fixed      s1Cv;

    // Pixel column to fixed point
    assign fixX = fixedPkg::Fixed'(pixelX) <<< `FRAC_BITS;
    // Screen y is flipped against the viewport height
    assign fixY = (fixedPkg::Fixed'(camera.vpHeight) - fixedPkg::Fixed'(1)
                   - fixedPkg::Fixed'(pixelY)) <<< `FRAC_BITS;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= issue;
        end
    end

    // Scalar scale factors for this pixel
    always_ff @(posedge clk) begin
        if (issue) begin
            s1X  <= pixelX;
            s1Y  <= pixelY;
            s1Cu <= fixedMul(fixX, camera.cub);
            s1Cv <= fixedMul(fixY, camera.cvb);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stage two
    ////////////////////////////////////////////////////////////////////////

    logic                s2Valid;
    rayPkg::ScreenCoord  s2X;
    rayPkg::ScreenCoord  s2Y;
    fixedPkg::Vec3       s2Dir;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            s2Valid <= 1'b0;
        end else begin
            s2Valid <= s1Valid;
        end
    end

    // Direction sum per component
    always_ff @(posedge clk) begin
        if (s1Valid) begin
            s2X     <= s1X;
            s2Y     <= s1Y;
            s2Dir.x <= dirComp(s1Cu, s1Cv, camera.rh.x, camera.rv.x,
                               camera.blc.x, camera.pos.x);
            s2Dir.y <= dirComp(s1Cu, s1Cv, camera.rh.y, camera.rv.y,
                               camera.blc.y, camera.pos.y);
            s2Dir.z <= dirComp(s1Cu, s1Cv, camera.rh.z, camera.rv.z,
                               camera.blc.z, camera.pos.z);
        end
    end

    // Thread straight from the second stage
    assign thread.valid = s2Valid;
    assign thread.x     = s2X;
    assign thread.y     = s2Y;
    assign thread.dir   = s2Dir;

endmodule

//--- hw/rayGen.sv
`timescale 1ns/1ps

`include "rayGen_params.svh"

module rayGen (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  restart,
    input  logic                                  start,
    input  rayPkg::ScreenCoord                    x0,
    input  rayPkg::ScreenCoord                    y0,
    input  rayPkg::CameraParams                   camera,
    input  logic [`CORE_COUNT-1:0]                fifoFull,
    output rayPkg::ThreadData [`CORE_COUNT-1:0]   threads,
    output logic                                  frameDone
);

    ////////////////////////////////////////////////////////////////////////
    // Scanner to lanes
    ////////////////////////////////////////////////////////////////////////

    // One hot lane strobes
    logic [`CORE_COUNT-1:0]  issue;
    // Pixel shared by every lane
    rayPkg::ScreenCoord      pixelX;
    rayPkg::ScreenCoord      pixelY;

    // Raster walk and round robin dispatch
    pixelScanner scanner (
        .clk       (clk),
        .resetn    (resetn),
        .restart   (restart),
        .start     (start),
        .x0        (x0),
        .y0        (y0),
        .fifoFull  (fifoFull),
        .issue     (issue),
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .frameDone (frameDone)
    );

    ////////////////////////////////////////////////////////////////////////
    // Ray setup lanes
    ////////////////////////////////////////////////////////////////////////

    // Lane i owns issue bit i and thread port i
    generate
        for (genvar i = 0; i < `CORE_COUNT; i++) begin : laneGen
            rayLane lane (
                .clk    (clk),
                .resetn (resetn),
                .issue  (issue[i]),
                .pixelX (pixelX),
                .pixelY (pixelY),
                .camera (camera),
                .thread (threads[i])
            );
        end
    endgenerate

endmodule

//--- testbench/rayGenTb.sv
`timescale 1ns/1ps

`include "rayGen_params.svh"

module rayGenTb;

    typedef logic [`CORE_INDEX_WIDTH-1:0] LaneIdx;

    ////////////////////////////////////////////////////////////////////////////
    // DUT and clock
    ////////////////////////////////////////////////////////////////////////////

    logic clk = 1'b0;
    logic resetn;
    logic restart;
    logic start;
    rayPkg::ScreenCoord x0;
    rayPkg::ScreenCoord y0;
    rayPkg::CameraParams camera;
    logic [`CORE_COUNT-1:0] fifoFull;
    rayPkg::ThreadData [`CORE_COUNT-1:0] threads;
    logic frameDone;

    // 40 ns period
    always #20 clk = ~clk;

    rayGen uut (
        .clk       (clk),
        .resetn    (resetn),
        .restart   (restart),
        .start     (start),
        .x0        (x0),
        .y0        (y0),
        .camera    (camera),
        .fifoFull  (fifoFull),
        .threads   (threads),
        .frameDone (frameDone)
    );

    // Bookkeeping
    int errors = 0;
    int checkCount = 0;
    int testsRun = 0;
    logic [31:0] lfsrState = 32'hec8739db;

    // Monitor results and model output
    rayPkg::ThreadData gotThreads[$];
    LaneIdx gotLanes[$];
    rayPkg::ThreadData expThreads[$];
    int doneCount = 0;
    logic lateThread = 1'b0;
    // fifoFull as seen at the last two rising edges
    logic [`CORE_COUNT-1:0] fullHist1 = '0;
    logic [`CORE_COUNT-1:0] fullHist2 = '0;

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////////////////////////////////////////

    // Galois step, one bit out per call
    function automatic logic lfsrBit();
        logic out;
        out = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (out) begin
            lfsrState = lfsrState ^ 32'hA3000000;
        end
        return out;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsrBit();
        end
        return v;
    endfunction

    // n random bits, sign extended
    function automatic fixedPkg::Fixed signedRand(input int n);
        logic [31:0] v;
        v = randBits(n);
        if (v[n-1]) begin
            v = v | (32'hffffffff << n);
        end
        return fixedPkg::Fixed'(v);
    endfunction

    function automatic fixedPkg::Vec3 randomVec();
        fixedPkg::Vec3 v;
        v.x = signedRand(24);
        v.y = signedRand(24);
        v.z = signedRand(24);
        return v;
    endfunction

    function automatic rayPkg::CameraParams randomCamera();
        rayPkg::CameraParams c;
        c.pos = randomVec();
        c.blc = randomVec();
        c.rh = randomVec();
        c.rv = randomVec();
        // Small scale factors, roughly +-2.0
        c.cub = signedRand(18);
        c.cvb = signedRand(18);
        c.vpHeight = rayPkg::ScreenCoord'(randBits(`COORD_WIDTH));
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Full signed product, arithmetic shift, keep low word
    function automatic fixedPkg::Fixed fixedTimes(input fixedPkg::Fixed a,
                                                  input fixedPkg::Fixed b);
        longint full;
        full = longint'(a) * longint'(b);
        return fixedPkg::Fixed'(full >>> `FRAC_BITS);
    endfunction

    function automatic fixedPkg::Vec3 expectedDir(input rayPkg::CameraParams cam,
                                                  input int px, input int py);
        fixedPkg::Fixed sx;
        fixedPkg::Fixed sy;
        fixedPkg::Fixed cu;
        fixedPkg::Fixed cv;
        fixedPkg::Vec3 d;
        sx = fixedPkg::Fixed'(px * (1 << `FRAC_BITS));
        // Screen y counted down from the viewport top
        sy = fixedPkg::Fixed'((int'(cam.vpHeight) - 1 - py) * (1 << `FRAC_BITS));
        cu = fixedTimes(sx, cam.cub);
        cv = fixedTimes(sy, cam.cvb);
        d.x = fixedTimes(cu, cam.rh.x) + fixedTimes(cv, cam.rv.x) + cam.blc.x - cam.pos.x;
        d.y = fixedTimes(cu, cam.rh.y) + fixedTimes(cv, cam.rv.y) + cam.blc.y - cam.pos.y;
        d.z = fixedTimes(cu, cam.rh.z) + fixedTimes(cv, cam.rv.z) + cam.blc.z - cam.pos.z;
        return d;
    endfunction

    // Raster walk from (sx, sy), every line restarts at sx
    task automatic buildExpected(input int sx, input int sy, input rayPkg::CameraParams cam);
        rayPkg::ThreadData t;
        expThreads.delete();
        for (int y = sy; y < `FRAME_HEIGHT; y++) begin
            for (int x = sx; x < `FRAME_WIDTH; x++) begin
                t.valid = 1'b1;
                t.x = rayPkg::ScreenCoord'(x);
                t.y = rayPkg::ScreenCoord'(y);
                t.dir = expectedDir(cam, x, y);
                expThreads.push_back(t);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkThread(input string name, input rayPkg::ThreadData exp,
                               input rayPkg::ThreadData got);
        checkCount++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic checkLane(input string name, input LaneIdx exp, input LaneIdx got);
        checkCount++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic got);
        checkCount++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, got);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        fullHist1 <= fifoFull;
        fullHist2 <= fullHist1;
    end

    // Outputs settle after the rising edge, sample on the falling one
    always @(negedge clk) begin
        if (resetn) begin
            for (int i = 0; i < `CORE_COUNT; i++) begin
                if (threads[i].valid) begin
                    if (doneCount != 0) begin
                        lateThread = 1'b1;
                    end
                    gotThreads.push_back(threads[i]);
                    gotLanes.push_back(LaneIdx'(i));
                    // Issue edge was two edges back, lane must have had room
                    checkBit($sformatf("fifoFull[%0d] at issue", i), 1'b0, fullHist2[i]);
                end
            end
            if (frameDone) begin
                doneCount++;
            end
        end
    end

    task automatic clearMonitor();
        gotThreads.delete();
        gotLanes.delete();
        doneCount = 0;
        lateThread = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Frame helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic reportTest(input string name, input int errsBefore);
        testsRun++;
        if (errors == errsBefore) begin
            $display("%s finished, no errors", name);
        end else begin
            $display("%s finished, %0d errors", name, errors - errsBefore);
        end
    endtask

    task automatic compareFrame(input string name);
        int i;
        i = 0;
        while (i < expThreads.size() && i < gotThreads.size()) begin
            checkThread($sformatf("threads[%0d] #%0d", gotLanes[i], i),
                        expThreads[i], gotThreads[i]);
            checkLane($sformatf("lane of thread #%0d", i),
                      LaneIdx'(i % `CORE_COUNT), gotLanes[i]);
            i++;
        end
        if (gotThreads.size() < expThreads.size()) begin
            $display("%s: only %0d of %0d threads arrived", name,
                     gotThreads.size(), expThreads.size());
            errors++;
        end
        if (gotThreads.size() > expThreads.size()) begin
            $display("%s: %0d threads arrived where %0d were expected", name,
                     gotThreads.size(), expThreads.size());
            errors++;
        end
        checkBit("frameDone single pulse", 1'b1, doneCount == 1);
        checkBit("thread after frameDone", 1'b0, lateThread);
    endtask

    // Restart, start and run one frame to frameDone
    task automatic runFrame(input string name, input int sx, input int sy,
                            input bit randomFull);
        rayPkg::CameraParams cam;
        int cycles;
        clearMonitor();
        @(negedge clk);
        cam = randomCamera();
        camera = cam;
        x0 = rayPkg::ScreenCoord'(sx);
        y0 = rayPkg::ScreenCoord'(sy);
        fifoFull = '0;
        restart = 1'b1;
        start = 1'b0;
        buildExpected(sx, sy, cam);
        @(negedge clk);
        restart = 1'b0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (doneCount == 0 && cycles < 1000) begin
            @(negedge clk);
            if (randomFull) begin
                fifoFull = `CORE_COUNT'(randBits(`CORE_COUNT));
            end
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        fifoFull = '0;
        if (doneCount == 0) begin
            $display("%s: no frameDone within %0d cycles", name, cycles);
            errors++;
        end
        // Give stray threads time to show up
        repeat (12) @(posedge clk);
        compareFrame(name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testIdle();
        int errsBefore;
        int cycles;
        errsBefore = errors;
        clearMonitor();
        // Start alone must not leave scanInit
        start = 1'b1;
        cycles = 0;
        while (cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        checkBit("threads valid while idle", 1'b0, gotThreads.size() != 0);
        checkBit("frameDone while idle", 1'b0, doneCount != 0);
        @(negedge clk);
        start = 1'b0;
        @(posedge clk);
        reportTest("testIdle", errsBefore);
    endtask

    task automatic testFullFrame();
        int errsBefore;
        errsBefore = errors;
        runFrame("testFullFrame", 0, 0, 1'b0);
        reportTest("testFullFrame", errsBefore);
    endtask

    task automatic testOffsetStart();
        int errsBefore;
        errsBefore = errors;
        runFrame("testOffsetStart", 5, 1, 1'b0);
        reportTest("testOffsetStart", errsBefore);
    endtask

    task automatic testBackPressure();
        int errsBefore;
        errsBefore = errors;
        runFrame("testBackPressure", 0, 0, 1'b1);
        reportTest("testBackPressure", errsBefore);
    endtask

    // Two frames back to back, each with its own camera
    task automatic testSecondFrame();
        int errsBefore;
        errsBefore = errors;
        runFrame("testSecondFrame first", 0, 0, 1'b0);
        runFrame("testSecondFrame second", 0, 0, 1'b0);
        reportTest("testSecondFrame", errsBefore);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        resetn = 1'b0;
        restart = 1'b0;
        start = 1'b0;
        x0 = '0;
        y0 = '0;
        camera = '0;
        fifoFull = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        testIdle();
        testFullFrame();
        testOffsetStart();
        testBackPressure();
        testSecondFrame();

        $display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/fixedPkg.sv
hw/rayPkg.sv
hw/pixelScanner.sv
hw/rayLane.sv
hw/rayGen.sv
testbench/rayGenTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/1ps -Wno-fatal \
		-f vlog.f --top-module rayGenTb -Mdir obj_dir -o rayGenSim
	./obj_dir/rayGenSim | tee /dev/stderr | grep "Everything OK" > /dev/null

clean:
	rm -rf obj_dir
